// ==== src/rv_decode_pkg.sv ====
// shared widths, instruction kinds and control encodings for the rv64i decode stage
package rv_decode_pkg;

  localparam int XLEN  = 64;
  localparam int NREGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes, bits [6:0]
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_32     = 7'b0111011;

  typedef enum logic [5:0] {
    kind_none,
    kind_lui, kind_auipc, kind_jal, kind_jalr,
    kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu,
    kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu, kind_lwu, kind_ld,
    kind_sb, kind_sh, kind_sw, kind_sd,
    kind_addi, kind_slti, kind_sltiu, kind_xori, kind_ori, kind_andi,
    kind_slli, kind_srli, kind_srai,
    kind_add, kind_sub, kind_sll, kind_slt, kind_sltu,
    kind_xor, kind_srl, kind_sra, kind_or, kind_and,
    kind_addiw, kind_slliw, kind_srliw, kind_sraiw,
    kind_addw, kind_subw, kind_sllw, kind_srlw, kind_sraw
  } inst_kind_t;

  typedef enum logic [2:0] {
    fmt_i = 3'd0, fmt_u = 3'd1, fmt_s = 3'd2, fmt_b = 3'd3, fmt_j = 3'd4, fmt_none = 3'd7
  } imm_fmt_t;

  typedef enum logic [4:0] {
    alu_add      = 5'd0,
    alu_sub      = 5'd1,
    alu_slt      = 5'd2,
    alu_sltu     = 5'd3,
    alu_xor      = 5'd4,
    alu_and      = 5'd5,
    alu_or       = 5'd6,
    alu_sll      = 5'd7,
    alu_srl      = 5'd8,
    alu_sra      = 5'd9,
    alu_copy_imm = 5'd15, // lui, result is b
    alu_invalid  = 5'd31
  } alu_op_t;

  // stores share the signed codes
  typedef enum logic [2:0] {
    mem_byte, mem_byte_u, mem_half, mem_half_u, mem_word, mem_word_u, mem_double, mem_none
  } mem_op_t;

  typedef enum logic [2:0] {
    br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } br_func_t;

  typedef enum logic [1:0] {
    b_src_rs2 = 2'd0, b_src_imm = 2'd1, b_src_four = 2'd2
  } alu_b_src_t;

endpackage

// ==== src/inst_classifier.sv ====
// decodes a 32-bit instruction word into one rv64i instruction kind and its immediate format
`timescale 1ns/1ps

module inst_classifier (
  input  rv_decode_pkg::inst_t      i_inst,
  output rv_decode_pkg::inst_kind_t o_kind,
  output rv_decode_pkg::imm_fmt_t   o_fmt,
  output logic                      o_invalid
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    o_kind = kind_none;
    case (opcode)
      op_lui:   o_kind = kind_lui;
      op_auipc: o_kind = kind_auipc;
      op_jal:   o_kind = kind_jal;
      op_jalr:  if (funct3 == 3'b000) o_kind = kind_jalr;
      op_branch: begin
        case (funct3)
          3'b000:  o_kind = kind_beq;
          3'b001:  o_kind = kind_bne;
          3'b100:  o_kind = kind_blt;
          3'b101:  o_kind = kind_bge;
          3'b110:  o_kind = kind_bltu;
          3'b111:  o_kind = kind_bgeu;
          default: o_kind = kind_none;
        endcase
      end
      op_load: begin
        case (funct3)
          3'b000:  o_kind = kind_lb;
          3'b001:  o_kind = kind_lh;
          3'b010:  o_kind = kind_lw;
          3'b011:  o_kind = kind_ld;
          3'b100:  o_kind = kind_lbu;
          3'b101:  o_kind = kind_lhu;
          3'b110:  o_kind = kind_lwu;
          default: o_kind = kind_none;
        endcase
      end
      op_store: begin
        case (funct3)
          3'b000:  o_kind = kind_sb;
          3'b001:  o_kind = kind_sh;
          3'b010:  o_kind = kind_sw;
          3'b011:  o_kind = kind_sd;
          default: o_kind = kind_none;
        endcase
      end
      op_imm: begin
        case (funct3)
          3'b000: o_kind = kind_addi;
          3'b010: o_kind = kind_slti;
          3'b011: o_kind = kind_sltiu;
          3'b100: o_kind = kind_xori;
          3'b110: o_kind = kind_ori;
          3'b111: o_kind = kind_andi;
          3'b001: if (funct7[6:1] == 6'b000000) o_kind = kind_slli; // shamt[5] in funct7[0]
          3'b101: begin
            if (funct7[6:1] == 6'b000000) o_kind = kind_srli;
            else if (funct7[6:1] == 6'b010000) o_kind = kind_srai;
          end
          default: o_kind = kind_none;
        endcase
      end
      op_imm_32: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b001}: o_kind = kind_slliw;
          {7'b0000000, 3'b101}: o_kind = kind_srliw;
          {7'b0100000, 3'b101}: o_kind = kind_sraiw;
          default: if (funct3 == 3'b000) o_kind = kind_addiw; // addiw ignores funct7
        endcase
      end
      op_op: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_kind = kind_add;
          {7'b0100000, 3'b000}: o_kind = kind_sub;
          {7'b0000000, 3'b001}: o_kind = kind_sll;
          {7'b0000000, 3'b010}: o_kind = kind_slt;
          {7'b0000000, 3'b011}: o_kind = kind_sltu;
          {7'b0000000, 3'b100}: o_kind = kind_xor;
          {7'b0000000, 3'b101}: o_kind = kind_srl;
          {7'b0100000, 3'b101}: o_kind = kind_sra;
          {7'b0000000, 3'b110}: o_kind = kind_or;
          {7'b0000000, 3'b111}: o_kind = kind_and;
          default:              o_kind = kind_none; // mul/div land here
        endcase
      end
      op_32: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_kind = kind_addw;
          {7'b0100000, 3'b000}: o_kind = kind_subw;
          {7'b0000000, 3'b001}: o_kind = kind_sllw;
          {7'b0000000, 3'b101}: o_kind = kind_srlw;
          {7'b0100000, 3'b101}: o_kind = kind_sraw;
          default:              o_kind = kind_none;
        endcase
      end
      default: o_kind = kind_none; // system and unknown opcodes
    endcase
  end

  always_comb begin
    case (o_kind)
      kind_lui, kind_auipc: o_fmt = fmt_u;
      kind_jal:             o_fmt = fmt_j;
      kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu: o_fmt = fmt_b;
      kind_sb, kind_sh, kind_sw, kind_sd:                           o_fmt = fmt_s;
      kind_jalr, kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu, kind_lwu, kind_ld,
      kind_addi, kind_slti, kind_sltiu, kind_xori, kind_ori, kind_andi,
      kind_slli, kind_srli, kind_srai,
      kind_addiw, kind_slliw, kind_srliw, kind_sraiw:               o_fmt = fmt_i;
      default:              o_fmt = fmt_none; // r-type and unknown
    endcase
  end

  assign o_invalid = (o_kind == kind_none) && (i_inst != '0);

endmodule

// ==== src/imm_gen.sv ====
// produces the sign-extended 64-bit immediate of an instruction for a given format
`timescale 1ns/1ps

module imm_gen (
  input  rv_decode_pkg::inst_t    i_inst,
  input  rv_decode_pkg::imm_fmt_t i_fmt,
  output rv_decode_pkg::xlen_t    o_imm
);
  import rv_decode_pkg::*;

  xlen_t imm_i;
  xlen_t imm_u;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_j;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      fmt_i:   o_imm = imm_i;
      fmt_u:   o_imm = imm_u;
      fmt_s:   o_imm = imm_s;
      fmt_b:   o_imm = imm_b;
      fmt_j:   o_imm = imm_j;
      default: o_imm = '0; // fmt_none, r-type
    endcase
  end

endmodule

// ==== src/ctrl_gen.sv ====
// maps a decoded instruction kind to the execute, memory and branch control fields
`timescale 1ns/1ps

module ctrl_gen (
  input  rv_decode_pkg::inst_kind_t i_kind,
  output rv_decode_pkg::alu_op_t    o_alu_op,
  output logic                      o_alu_a_src,
  output rv_decode_pkg::alu_b_src_t o_alu_b_src,
  output logic                      o_word_cut,
  output logic                      o_reg_wr,
  output logic                      o_mem_to_reg,
  output logic                      o_mem_wr,
  output logic                      o_mem_re,
  output rv_decode_pkg::mem_op_t    o_mem_op,
  output logic                      o_br_en,
  output rv_decode_pkg::br_func_t   o_br_func
);
  import rv_decode_pkg::*;

  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_jump;
  logic is_u;
  logic is_i_alu;
  logic is_r;

  assign is_load   = i_kind inside {kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu,
                                    kind_lwu, kind_ld};
  assign is_store  = i_kind inside {kind_sb, kind_sh, kind_sw, kind_sd};
  assign is_branch = i_kind inside {kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu,
                                    kind_bgeu};
  assign is_jump   = i_kind inside {kind_jal, kind_jalr};
  assign is_u      = i_kind inside {kind_lui, kind_auipc};
  assign is_i_alu  = i_kind inside {kind_addi, kind_slti, kind_sltiu, kind_xori, kind_ori,
                                    kind_andi, kind_slli, kind_srli, kind_srai, kind_addiw,
                                    kind_slliw, kind_srliw, kind_sraiw};
  assign is_r      = i_kind inside {kind_add, kind_sub, kind_sll, kind_slt, kind_sltu,
                                    kind_xor, kind_srl, kind_sra, kind_or, kind_and,
                                    kind_addw, kind_subw, kind_sllw, kind_srlw, kind_sraw};

  assign o_word_cut = i_kind inside {kind_addiw, kind_slliw, kind_srliw, kind_sraiw,
                                     kind_addw, kind_subw, kind_sllw, kind_srlw, kind_sraw};

  assign o_reg_wr     = is_r | is_i_alu | is_load | is_u | is_jump;
  assign o_alu_a_src  = is_jump | (i_kind == kind_auipc); // pc as operand a
  assign o_alu_b_src  = is_jump ? b_src_four :            // link address pc + 4
                        (is_i_alu | is_load | is_store | is_u) ? b_src_imm : b_src_rs2;
  assign o_mem_to_reg = is_load;
  assign o_mem_re     = is_load;
  assign o_mem_wr     = is_store;
  assign o_br_en      = is_branch | is_jump;

  always_comb begin
    case (i_kind)
      kind_lui: o_alu_op = alu_copy_imm;
      kind_auipc, kind_jal, kind_jalr, kind_add, kind_addi, kind_addw, kind_addiw,
      kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu, kind_lwu, kind_ld,
      kind_sb, kind_sh, kind_sw, kind_sd: o_alu_op = alu_add; // also address calc
      kind_sub, kind_subw,
      kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu: o_alu_op = alu_sub;
      kind_slt, kind_slti:                      o_alu_op = alu_slt;
      kind_sltu, kind_sltiu:                    o_alu_op = alu_sltu;
      kind_xor, kind_xori:                      o_alu_op = alu_xor;
      kind_and, kind_andi:                      o_alu_op = alu_and;
      kind_or, kind_ori:                        o_alu_op = alu_or;
      kind_sll, kind_slli, kind_sllw, kind_slliw: o_alu_op = alu_sll;
      kind_srl, kind_srli, kind_srlw, kind_srliw: o_alu_op = alu_srl;
      kind_sra, kind_srai, kind_sraw, kind_sraiw: o_alu_op = alu_sra;
      default:                                  o_alu_op = alu_invalid;
    endcase
  end

  always_comb begin
    case (i_kind)
      kind_lb, kind_sb: o_mem_op = mem_byte;
      kind_lbu:         o_mem_op = mem_byte_u;
      kind_lh, kind_sh: o_mem_op = mem_half;
      kind_lhu:         o_mem_op = mem_half_u;
      kind_lw, kind_sw: o_mem_op = mem_word;
      kind_lwu:         o_mem_op = mem_word_u;
      kind_ld, kind_sd: o_mem_op = mem_double;
      default:          o_mem_op = mem_none;
    endcase
  end

  always_comb begin
    case (i_kind)
      kind_jalr: o_br_func = br_jalr;
      kind_beq:  o_br_func = br_beq;
      kind_bne:  o_br_func = br_bne;
      kind_blt:  o_br_func = br_blt;
      kind_bge:  o_br_func = br_bge;
      kind_bltu: o_br_func = br_bltu;
      kind_bgeu: o_br_func = br_bgeu;
      default:   o_br_func = br_jal; // jal, or no branch
    endcase
  end

endmodule

// ==== src/gpr_file.sv ====
// general-purpose register file, two combinational reads and one clocked write, x0 reads zero
`timescale 1ns/1ps

module gpr_file (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  rv_decode_pkg::reg_addr_t i_raddr1,
  input  rv_decode_pkg::reg_addr_t i_raddr2,
  input  logic                     i_wen,
  input  rv_decode_pkg::reg_addr_t i_waddr,
  input  rv_decode_pkg::xlen_t     i_wdata,
  output rv_decode_pkg::xlen_t     o_rdata1,
  output rv_decode_pkg::xlen_t     o_rdata2
);
  import rv_decode_pkg::*;

  xlen_t regs [1:NREGS-1]; // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write bypass, old value seen in the write cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== src/decode_unit.sv ====
// instruction decode stage top, joins classifier, immediate and control generation with the gprs
`timescale 1ns/1ps

module decode_unit (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  rv_decode_pkg::inst_t      i_inst,
  input  logic                      i_rf_wen,
  input  rv_decode_pkg::reg_addr_t  i_rf_waddr,
  input  rv_decode_pkg::xlen_t      i_rf_wdata,
  output rv_decode_pkg::reg_addr_t  o_rd,
  output rv_decode_pkg::xlen_t      o_rs1_data,
  output rv_decode_pkg::xlen_t      o_rs2_data,
  output rv_decode_pkg::xlen_t      o_imm,
  output logic                      o_invalid,
  output rv_decode_pkg::alu_op_t    o_alu_op,
  output logic                      o_alu_a_src,
  output rv_decode_pkg::alu_b_src_t o_alu_b_src,
  output logic                      o_word_cut,
  output logic                      o_reg_wr,
  output logic                      o_mem_to_reg,
  output logic                      o_mem_wr,
  output logic                      o_mem_re,
  output rv_decode_pkg::mem_op_t    o_mem_op,
  output logic                      o_br_en,
  output rv_decode_pkg::br_func_t   o_br_func
);
  import rv_decode_pkg::*;

  reg_addr_t  rs1;
  reg_addr_t  rs2;
  inst_kind_t kind;
  imm_fmt_t   fmt;

  assign o_rd = i_inst[11:7];
  assign rs1  = i_inst[19:15];
  assign rs2  = i_inst[24:20];

  inst_classifier u_classifier (
    .i_inst(i_inst), .o_kind(kind), .o_fmt(fmt), .o_invalid(o_invalid)
  );

  imm_gen u_imm_gen (
    .i_inst(i_inst), .i_fmt(fmt), .o_imm(o_imm)
  );

  ctrl_gen u_ctrl_gen (
    .i_kind(kind),
    .o_alu_op(o_alu_op), .o_alu_a_src(o_alu_a_src), .o_alu_b_src(o_alu_b_src),
    .o_word_cut(o_word_cut), .o_reg_wr(o_reg_wr), .o_mem_to_reg(o_mem_to_reg),
    .o_mem_wr(o_mem_wr), .o_mem_re(o_mem_re), .o_mem_op(o_mem_op),
    .o_br_en(o_br_en), .o_br_func(o_br_func)
  );

  gpr_file u_gpr_file (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_raddr1(rs1), .i_raddr2(rs2),
    .i_wen(i_rf_wen), .i_waddr(i_rf_waddr), .i_wdata(i_rf_wdata), // write-back port
    .o_rdata1(o_rs1_data), .o_rdata2(o_rs2_data)
  );

endmodule

// ==== tb/tb_clock.sv ====
// free-running testbench clock, 100 ns period, starts low and first rises at 50 ns
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #50 o_clk = ~o_clk; // half period
    end
  end

endmodule

// ==== tb/tb_decode_unit.sv ====
// testbench for decode_unit, checks gpr reset and writes, then applies the instruction table
`timescale 1ns/1ps

module tb_decode_unit;
  import rv_decode_pkg::*;

  // flags are {a_src, word_cut, reg_wr, mem_to_reg, mem_re, mem_wr, br_en, invalid}
  typedef struct packed {
    inst_t      inst;
    xlen_t      imm;
    alu_op_t    alu;
    alu_b_src_t b_src;
    mem_op_t    mop;
    br_func_t   br_fn;
    logic [7:0] flags;
  } row_t;

  logic       clk;
  logic       reset;
  inst_t      inst;
  logic       rf_wen;
  reg_addr_t  rf_waddr;
  xlen_t      rf_wdata;
  reg_addr_t  rd;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      imm;
  logic       invalid;
  alu_op_t    alu_op;
  logic       alu_a_src;
  alu_b_src_t alu_b_src;
  logic       word_cut;
  logic       reg_wr;
  logic       mem_to_reg;
  logic       mem_wr;
  logic       mem_re;
  mem_op_t    mem_op;
  logic       br_en;
  br_func_t   br_func;

  string       names[$];
  row_t        rows[$];
  logic [15:0] lfsr;

  tb_clock u_clock (.o_clk(clk));

  decode_unit DUT (
    .i_clk(clk), .i_reset(reset), .i_inst(inst),
    .i_rf_wen(rf_wen), .i_rf_waddr(rf_waddr), .i_rf_wdata(rf_wdata),
    .o_rd(rd), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_imm(imm),
    .o_invalid(invalid), .o_alu_op(alu_op), .o_alu_a_src(alu_a_src),
    .o_alu_b_src(alu_b_src), .o_word_cut(word_cut), .o_reg_wr(reg_wr),
    .o_mem_to_reg(mem_to_reg), .o_mem_wr(mem_wr), .o_mem_re(mem_re),
    .o_mem_op(mem_op), .o_br_en(br_en), .o_br_func(br_func)
  );

  // instruction encoders, table rows use rs1 x1, rs2 x3, rd x2
  function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, logic [6:0] op);
    return {f7, rs2, rs1, f3, 5'd2, op};
  endfunction

  function automatic inst_t enc_i(logic [31:0] v, logic [2:0] f3, logic [6:0] op);
    return {v[11:0], 5'd1, f3, 5'd2, op};
  endfunction

  function automatic inst_t enc_s(logic [31:0] v, logic [2:0] f3);
    return {v[11:5], 5'd3, 5'd1, f3, v[4:0], op_store};
  endfunction

  function automatic inst_t enc_b(logic [31:0] v, logic [2:0] f3);
    return {v[12], v[10:5], 5'd3, 5'd1, f3, v[4:1], v[11], op_branch};
  endfunction

  function automatic inst_t enc_u(logic [31:0] v, logic [6:0] op);
    return {v[19:0], 5'd2, op}; // v is the upper 20 bits
  endfunction

  function automatic inst_t enc_j(logic [31:0] v);
    return {v[20], v[10:1], v[11], v[19:12], 5'd2, op_jal};
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output xlen_t v);
    for (int b = 0; b < XLEN; b++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[XLEN-2:0], lfsr[0]}; // one step per bit
    end
  endtask

  task automatic fail_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check(string name, xlen_t exp, xlen_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      fail_run();
    end
  endtask

  // returns 5 ns after the next rising edge, polls off the clock grid
  task automatic next_cycle();
    int   polls;
    logic prev;
    polls = 0;
    #0.5;
    prev = clk;
    #1;
    while (!(prev === 1'b0 && clk === 1'b1)) begin
      if (polls == 150) begin
        $display("no rising clock edge within 150 ns, the clock has stopped");
        fail_run();
      end else begin
        prev  = clk;
        polls = polls + 1;
        #1;
      end
    end
    #4.5;
  endtask

  task automatic add_row(string name, inst_t word, longint imm_v, alu_op_t alu,
                         alu_b_src_t b_src, mem_op_t mop, br_func_t bfn, logic [7:0] flags);
    row_t r;
    r = '{word, imm_v, alu, b_src, mop, bfn, flags};
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row("add", enc_r(7'h00, 3, 1, 3'd0, op_op), 0, alu_add, b_src_rs2, mem_none, br_jal,
            8'b0010_0000);
    add_row("sub", enc_r(7'h20, 3, 1, 3'd0, op_op), 0, alu_sub, b_src_rs2, mem_none, br_jal,
            8'b0010_0000);
    add_row("slti", enc_i(-5, 3'd2, op_imm), -5, alu_slt, b_src_imm, mem_none, br_jal,
            8'b0010_0000);
    add_row("sltu", enc_r(7'h00, 3, 1, 3'd3, op_op), 0, alu_sltu, b_src_rs2, mem_none, br_jal,
            8'b0010_0000);
    add_row("xori", enc_i(2047, 3'd4, op_imm), 2047, alu_xor, b_src_imm, mem_none, br_jal,
            8'b0010_0000);
    add_row("and", enc_r(7'h00, 3, 1, 3'd7, op_op), 0, alu_and, b_src_rs2, mem_none, br_jal,
            8'b0010_0000);
    add_row("ori", enc_i(-256, 3'd6, op_imm), -256, alu_or, b_src_imm, mem_none, br_jal,
            8'b0010_0000);
    add_row("slli", enc_i(63, 3'd1, op_imm), 63, alu_sll, b_src_imm, mem_none, br_jal,
            8'b0010_0000);
    add_row("srl", enc_r(7'h00, 3, 1, 3'd5, op_op), 0, alu_srl, b_src_rs2, mem_none, br_jal,
            8'b0010_0000);
    add_row("srai", enc_i('h41f, 3'd5, op_imm), 'h41f, alu_sra, b_src_imm, mem_none, br_jal,
            8'b0010_0000); // funct7 0100000, shamt 31
    add_row("addiw", enc_i(-1, 3'd0, op_imm_32), -1, alu_add, b_src_imm, mem_none, br_jal,
            8'b0110_0000);
    add_row("sraiw", enc_i('h403, 3'd5, op_imm_32), 'h403, alu_sra, b_src_imm, mem_none,
            br_jal, 8'b0110_0000);
    add_row("subw", enc_r(7'h20, 3, 1, 3'd0, op_32), 0, alu_sub, b_src_rs2, mem_none, br_jal,
            8'b0110_0000);
    add_row("srlw", enc_r(7'h00, 3, 1, 3'd5, op_32), 0, alu_srl, b_src_rs2, mem_none, br_jal,
            8'b0110_0000);
    add_row("lb", enc_i(-8, 3'd0, op_load), -8, alu_add, b_src_imm, mem_byte, br_jal,
            8'b0011_1000);
    add_row("lh", enc_i(16, 3'd1, op_load), 16, alu_add, b_src_imm, mem_half, br_jal,
            8'b0011_1000);
    add_row("lw", enc_i(-2048, 3'd2, op_load), -2048, alu_add, b_src_imm, mem_word, br_jal,
            8'b0011_1000);
    add_row("ld", enc_i(2040, 3'd3, op_load), 2040, alu_add, b_src_imm, mem_double, br_jal,
            8'b0011_1000);
    add_row("lbu", enc_i(1, 3'd4, op_load), 1, alu_add, b_src_imm, mem_byte_u, br_jal,
            8'b0011_1000);
    add_row("lhu", enc_i(-2, 3'd5, op_load), -2, alu_add, b_src_imm, mem_half_u, br_jal,
            8'b0011_1000);
    add_row("lwu", enc_i(100, 3'd6, op_load), 100, alu_add, b_src_imm, mem_word_u, br_jal,
            8'b0011_1000);
    add_row("sb", enc_s(-8, 3'd0), -8, alu_add, b_src_imm, mem_byte, br_jal, 8'b0000_0100);
    add_row("sh", enc_s(2047, 3'd1), 2047, alu_add, b_src_imm, mem_half, br_jal, 8'b0000_0100);
    add_row("sw", enc_s(-2048, 3'd2), -2048, alu_add, b_src_imm, mem_word, br_jal,
            8'b0000_0100);
    add_row("sd", enc_s(40, 3'd3), 40, alu_add, b_src_imm, mem_double, br_jal, 8'b0000_0100);
    add_row("lui", enc_u('hfffff, op_lui), -4096, alu_copy_imm, b_src_imm, mem_none, br_jal,
            8'b0010_0000);
    add_row("auipc", enc_u('h12345, op_auipc), 'h12345000, alu_add, b_src_imm, mem_none,
            br_jal, 8'b1010_0000);
    add_row("jal", enc_j(-2048), -2048, alu_add, b_src_four, mem_none, br_jal, 8'b1010_0010);
    add_row("jalr", enc_i(-4, 3'd0, op_jalr), -4, alu_add, b_src_four, mem_none, br_jalr,
            8'b1010_0010);
    add_row("beq", enc_b(-16, 3'd0), -16, alu_sub, b_src_rs2, mem_none, br_beq, 8'b0000_0010);
    add_row("bne", enc_b(4094, 3'd1), 4094, alu_sub, b_src_rs2, mem_none, br_bne, 8'b0000_0010);
    add_row("blt", enc_b(-4096, 3'd4), -4096, alu_sub, b_src_rs2, mem_none, br_blt,
            8'b0000_0010);
    add_row("bge", enc_b(8, 3'd5), 8, alu_sub, b_src_rs2, mem_none, br_bge, 8'b0000_0010);
    add_row("bltu", enc_b(2048, 3'd6), 2048, alu_sub, b_src_rs2, mem_none, br_bltu,
            8'b0000_0010);
    add_row("bgeu", enc_b(-2, 3'd7), -2, alu_sub, b_src_rs2, mem_none, br_bgeu, 8'b0000_0010);
    add_row("mul", enc_r(7'h01, 3, 1, 3'd0, op_op), 0, alu_invalid, b_src_rs2, mem_none,
            br_jal, 8'b0000_0001); // m extension, not decoded
    add_row("csrrw", 32'h34011173, 0, alu_invalid, b_src_rs2, mem_none, br_jal, 8'b0000_0001);
    add_row("zero word", 32'h0, 0, alu_invalid, b_src_rs2, mem_none, br_jal, 8'b0000_0000);
  endtask

  initial begin
    xlen_t value;
    inst     = '0;
    rf_wen   = 1'b0;
    rf_waddr = '0;
    rf_wdata = '0;
    reset    = 1'b1;
    lfsr     = 16'd21322;
    build_table();
    repeat (3) next_cycle();
    reset = 1'b0;

    // every register reads zero after reset, on both ports
    for (int r = 0; r < NREGS; r++) begin
      inst = enc_r(7'h00, 5'(NREGS - 1 - r), 5'(r), 3'd0, op_op);
      next_cycle();
      check($sformatf("reset rs1 x%0d", r), 64'd0, rs1_data);
      check($sformatf("reset rs2 x%0d", NREGS - 1 - r), 64'd0, rs2_data);
    end

    // write a random word, read it back the next cycle
    for (int n = 0; n < NREGS; n++) begin
      rand_word(value);
      rf_wen   = 1'b1;
      rf_waddr = 5'(n);
      rf_wdata = value;
      inst     = enc_r(7'h00, 5'(n), 5'(n), 3'd0, op_op);
      next_cycle();
      check($sformatf("write x%0d rs1", n), (n == 0) ? 64'd0 : value, rs1_data);
      check($sformatf("write x%0d rs2", n), (n == 0) ? 64'd0 : value, rs2_data);
      rf_wen = 1'b0;
    end

    for (int k = 0; k < rows.size(); k++) begin
      inst = rows[k].inst;
      next_cycle();
      check({names[k], " imm"}, rows[k].imm, imm);
      check({names[k], " alu_op"}, rows[k].alu, alu_op);
      check({names[k], " alu_b_src"}, rows[k].b_src, alu_b_src);
      check({names[k], " mem_op"}, rows[k].mop, mem_op);
      check({names[k], " br_func"}, rows[k].br_fn, br_func);
      check({names[k], " flags"}, rows[k].flags,
            {alu_a_src, word_cut, reg_wr, mem_to_reg, mem_re, mem_wr, br_en, invalid});
      if (rows[k].flags[5]) begin
        check({names[k], " rd"}, 64'd2, rd); // encoders place rd at x2
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
src/rv_decode_pkg.sv
src/inst_classifier.sv
src/imm_gen.sv
src/ctrl_gen.sv
src/gpr_file.sv
src/decode_unit.sv
tb/tb_clock.sv
tb/tb_decode_unit.sv
